// ==== design/core_isa_pkg.sv ====
// ----------------------------------------
// instruction set of the core_lite pipeline
// opcode enum, field positions, memory sizes
// and the instruction encoder
// ----------------------------------------
`default_nettype none

package core_isa_pkg;

	localparam int XLEN    = 32;
	localparam int REG_AW  = 5;
	localparam int IMEM_AW = 6;
	localparam int DMEM_AW = 6;

	// field positions
	localparam int OP_LSB  = 28;
	localparam int OP_W    = 4;
	localparam int RD_LSB  = 23;
	localparam int RS1_LSB = 18;
	localparam int RS2_LSB = 13;
	localparam int IMM_W   = 13;

	typedef logic [XLEN-1:0]    word_t;
	typedef logic [REG_AW-1:0]  reg_t;
	typedef logic [IMEM_AW-1:0] pc_t;
	typedef logic [DMEM_AW-1:0] daddr_t;

	typedef enum logic [OP_W-1:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_ADDI = 4'h3,
		OP_LW   = 4'h4,
		OP_SW   = 4'h5,
		OP_BEQ  = 4'h6,
		OP_JAL  = 4'h7
	} opcode_e;

	// offsets of BEQ and JAL count words from the instruction's own pc
	function automatic word_t encode(opcode_e op, reg_t rd, reg_t rs1, reg_t rs2,
			logic [IMM_W-1:0] imm);
		word_t w;
		w = '0;
		w[OP_LSB +: OP_W]    = op;
		w[RD_LSB +: REG_AW]  = rd;
		w[RS1_LSB +: REG_AW] = rs1;
		w[RS2_LSB +: REG_AW] = rs2;
		w[IMM_W-1:0]         = imm;
		return w;
	endfunction

endpackage

`default_nettype wire

// ==== design/core_pipe_pkg.sv ====
// ----------------------------------------
// pipeline control definitions
// hazard classes, forwarding selects and
// stage register indices
// ----------------------------------------
`default_nettype none

package core_pipe_pkg;

	// width of the enable and kill buses
	localparam int NUM_STG = 4;

	// stage register indices
	localparam int STG_IF_DEC  = 0;
	localparam int STG_DEC_EXE = 1;
	localparam int STG_EXE_MEM = 2;
	localparam int STG_MEM_WB  = 3;

	// ----------------------------------------
	// instruction class seen by the hazard unit
	// ----------------------------------------
	typedef enum logic [1:0] {
		HZ_NONE   = 2'd0,
		HZ_JUMP   = 2'd1,
		HZ_BRANCH = 2'd2,
		HZ_LOAD   = 2'd3
	} hz_cmd_e;

	// source of an execute operand
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_e;

endpackage

`default_nettype wire

// ==== design/core_hazard_ctrl.sv ====
// ----------------------------------------
// hazard controller
// stall, flush, bubble and redirect control
// plus operand forwarding selects
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module core_hazard_ctrl (
	input  wire                          rst_n,
	input  wire                          hold,
	// decode stage
	input  wire core_isa_pkg::reg_t      dec_rs1,
	input  wire core_isa_pkg::reg_t      dec_rs2,
	input  wire core_pipe_pkg::hz_cmd_e  dec_cmd,
	// execute stage
	input  wire core_isa_pkg::reg_t      exe_rs1,
	input  wire core_isa_pkg::reg_t      exe_rs2,
	input  wire core_isa_pkg::reg_t      exe_rd,
	input  wire core_pipe_pkg::hz_cmd_e  exe_cmd,
	input  wire                          exe_we,
	input  wire                          exe_taken,
	// memory and write-back stages
	input  wire core_isa_pkg::reg_t      mem_rd,
	input  wire                          mem_we,
	input  wire core_isa_pkg::reg_t      wb_rd,
	input  wire                          wb_we,
	// stage register control
	output logic [core_pipe_pkg::NUM_STG-1:0] enb,
	output logic [core_pipe_pkg::NUM_STG-1:0] kill,
	output logic                         pc_stop,
	output logic                         redirect,
	output core_pipe_pkg::fwd_sel_e      fwd_a,
	output core_pipe_pkg::fwd_sel_e      fwd_b
);

	logic load_use;

	// newest producer wins, x0 always comes from the register file
	function automatic core_pipe_pkg::fwd_sel_e pick_src(core_isa_pkg::reg_t src,
			logic m_we, core_isa_pkg::reg_t m_rd, logic w_we, core_isa_pkg::reg_t w_rd);
		if (src == '0)
			return core_pipe_pkg::FWD_REG;
		if (m_we && m_rd == src)
			return core_pipe_pkg::FWD_MEM;
		if (w_we && w_rd == src)
			return core_pipe_pkg::FWD_WB;
		return core_pipe_pkg::FWD_REG;
	endfunction

	assign fwd_a = pick_src(exe_rs1, mem_we, mem_rd, wb_we, wb_rd);
	assign fwd_b = pick_src(exe_rs2, mem_we, mem_rd, wb_we, wb_rd);

	// a JAL in decode reads no register
	assign load_use = exe_cmd == core_pipe_pkg::HZ_LOAD && exe_we && exe_rd != '0
		&& dec_cmd != core_pipe_pkg::HZ_JUMP
		&& (exe_rd == dec_rs1 || exe_rd == dec_rs2);

	// ----------------------------------------
	// priority: hold, load-use, redirect
	// ----------------------------------------
	always_comb begin
		enb      = '1;
		kill     = '0;
		pc_stop  = 1'b0;
		redirect = 1'b0;
		if (!rst_n) begin
			kill = '1;
		end else if (hold) begin
			enb     = '0;
			pc_stop = 1'b1;
		end else if (load_use) begin
			// one bubble behind the load
			enb[core_pipe_pkg::STG_IF_DEC]   = 1'b0;
			enb[core_pipe_pkg::STG_DEC_EXE]  = 1'b0;
			kill[core_pipe_pkg::STG_DEC_EXE] = 1'b1;
			pc_stop                          = 1'b1;
		end else if (exe_taken) begin
			redirect                         = 1'b1;
			kill[core_pipe_pkg::STG_IF_DEC]  = 1'b1;
			kill[core_pipe_pkg::STG_DEC_EXE] = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/core_fetch.sv ====
// ----------------------------------------
// fetch stage
// program counter, instruction memory with
// its load port, fetch-to-decode register
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module core_fetch (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       imem_we,
	input  wire core_isa_pkg::pc_t    imem_addr,
	input  wire core_isa_pkg::word_t  imem_data,
	input  wire                       enb_if_dec,
	input  wire                       kill_if_dec,
	input  wire                       pc_stop,
	input  wire                       redirect,
	input  wire core_isa_pkg::pc_t    redirect_pc,
	output core_isa_pkg::word_t       dec_instr,
	output core_isa_pkg::pc_t         dec_pc,
	output logic                      dec_valid
);

	core_isa_pkg::word_t imem [2**core_isa_pkg::IMEM_AW];
	core_isa_pkg::pc_t   pc;

	// program load only while the core sits in reset
	always_ff @(posedge clk) begin
		if (!rst_n && imem_we)
			imem[imem_addr] <= imem_data;
	end

	// word-addressed, wraps at the end of memory
	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= '0;
		else if (redirect)
			pc <= redirect_pc;
		else if (!pc_stop)
			pc <= pc + 1'b1;
	end

	// ----------------------------------------
	// fetch-to-decode register
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n || kill_if_dec)
			dec_valid <= 1'b0;
		else if (enb_if_dec)
			dec_valid <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (enb_if_dec) begin
			dec_instr <= imem[pc];
			dec_pc    <= pc;
		end
	end

endmodule

`default_nettype wire

// ==== design/core_decode.sv ====
// ----------------------------------------
// decode stage
// field decoder, register file with
// write-through, decode-to-execute register
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module core_decode (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire core_isa_pkg::word_t      dec_instr,
	input  wire core_isa_pkg::pc_t        dec_pc,
	input  wire                           dec_valid,
	input  wire                           enb_dec_exe,
	input  wire                           kill_dec_exe,
	input  wire                           wb_we,
	input  wire core_isa_pkg::reg_t       wb_rd,
	input  wire core_isa_pkg::word_t      wb_data,
	output core_isa_pkg::reg_t            dec_rs1,
	output core_isa_pkg::reg_t            dec_rs2,
	output core_pipe_pkg::hz_cmd_e        dec_cmd,
	output core_isa_pkg::opcode_e         exe_op,
	output core_isa_pkg::reg_t            exe_rs1,
	output core_isa_pkg::reg_t            exe_rs2,
	output core_isa_pkg::reg_t            exe_rd,
	output logic                          exe_we,
	output core_pipe_pkg::hz_cmd_e        exe_cmd,
	output core_isa_pkg::word_t           exe_a,
	output core_isa_pkg::word_t           exe_b,
	output core_isa_pkg::word_t           exe_imm,
	output core_isa_pkg::pc_t             exe_pc,
	output logic                          exe_valid
);

	core_isa_pkg::opcode_e op;
	core_isa_pkg::reg_t    rd_f;
	core_isa_pkg::reg_t    rs1_f;
	core_isa_pkg::reg_t    rs2_f;
	core_isa_pkg::word_t   imm_f;
	core_isa_pkg::word_t   rd_a;
	core_isa_pkg::word_t   rd_b;
	core_isa_pkg::word_t   regs [2**core_isa_pkg::REG_AW];
	logic                  writes;

	// ----------------------------------------
	// field split
	// ----------------------------------------
	assign op    = core_isa_pkg::opcode_e'(dec_instr[core_isa_pkg::OP_LSB +: core_isa_pkg::OP_W]);
	assign rd_f  = dec_instr[core_isa_pkg::RD_LSB +: core_isa_pkg::REG_AW];
	assign rs1_f = dec_instr[core_isa_pkg::RS1_LSB +: core_isa_pkg::REG_AW];
	assign rs2_f = dec_instr[core_isa_pkg::RS2_LSB +: core_isa_pkg::REG_AW];
	assign imm_f = {{(core_isa_pkg::XLEN - core_isa_pkg::IMM_W){dec_instr[core_isa_pkg::IMM_W-1]}},
		dec_instr[core_isa_pkg::IMM_W-1:0]};

	// a bubble never asks for a stall
	assign dec_rs1 = dec_valid ? rs1_f : '0;
	assign dec_rs2 = dec_valid ? rs2_f : '0;

	always_comb begin
		dec_cmd = core_pipe_pkg::HZ_NONE;
		writes  = 1'b0;
		if (dec_valid) begin
			case (op)
				core_isa_pkg::OP_ADD, core_isa_pkg::OP_SUB,
				core_isa_pkg::OP_AND, core_isa_pkg::OP_ADDI: writes = 1'b1;
				core_isa_pkg::OP_LW: begin
					writes  = 1'b1;
					dec_cmd = core_pipe_pkg::HZ_LOAD;
				end
				core_isa_pkg::OP_BEQ: dec_cmd = core_pipe_pkg::HZ_BRANCH;
				core_isa_pkg::OP_JAL: begin
					writes  = 1'b1;
					dec_cmd = core_pipe_pkg::HZ_JUMP;
				end
				default: writes = 1'b0;
			endcase
		end
	end

	// ----------------------------------------
	// register file, write seen by same-cycle reads
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**core_isa_pkg::REG_AW; i++)
				regs[i] <= '0;
		end else if (wb_we && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	assign rd_a = (wb_we && rs1_f != '0 && wb_rd == rs1_f) ? wb_data : regs[rs1_f];
	assign rd_b = (wb_we && rs2_f != '0 && wb_rd == rs2_f) ? wb_data : regs[rs2_f];

	// decode-to-execute register, rd of x0 drops the write
	always_ff @(posedge clk) begin
		if (!rst_n || kill_dec_exe) begin
			exe_valid <= 1'b0;
			exe_we    <= 1'b0;
			exe_cmd   <= core_pipe_pkg::HZ_NONE;
		end else if (enb_dec_exe) begin
			exe_valid <= dec_valid;
			exe_we    <= writes && rd_f != '0;
			exe_cmd   <= dec_cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (enb_dec_exe) begin
			exe_op  <= op;
			exe_rs1 <= rs1_f;
			exe_rs2 <= rs2_f;
			exe_rd  <= rd_f;
			exe_a   <= rd_a;
			exe_b   <= rd_b;
			exe_imm <= imm_f;
			exe_pc  <= dec_pc;
		end
	end

endmodule

`default_nettype wire

// ==== design/core_execute.sv ====
// ----------------------------------------
// execute stage
// forwarding muxes, ALU, BEQ and JAL
// resolution, execute-to-memory register
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module core_execute (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire core_isa_pkg::opcode_e    exe_op,
	input  wire core_isa_pkg::reg_t       exe_rd,
	input  wire                           exe_we,
	input  wire core_isa_pkg::word_t      exe_a,
	input  wire core_isa_pkg::word_t      exe_b,
	input  wire core_isa_pkg::word_t      exe_imm,
	input  wire core_isa_pkg::pc_t        exe_pc,
	input  wire                           exe_valid,
	input  wire core_pipe_pkg::fwd_sel_e  fwd_a,
	input  wire core_pipe_pkg::fwd_sel_e  fwd_b,
	input  wire core_isa_pkg::word_t      wb_data,
	input  wire                           enb_exe_mem,
	input  wire                           kill_exe_mem,
	output logic                          exe_taken,
	output core_isa_pkg::pc_t             redirect_pc,
	output core_isa_pkg::opcode_e         mem_op,
	output core_isa_pkg::reg_t            mem_rd,
	output logic                          mem_we,
	output core_isa_pkg::word_t           mem_result,
	output core_isa_pkg::word_t           mem_store_data,
	output logic                          mem_valid
);

	core_isa_pkg::word_t op_a;
	core_isa_pkg::word_t op_b;
	core_isa_pkg::word_t alu;

	function automatic core_isa_pkg::word_t fwd_mux(core_pipe_pkg::fwd_sel_e sel,
			core_isa_pkg::word_t reg_v, core_isa_pkg::word_t mem_v, core_isa_pkg::word_t wb_v);
		case (sel)
			core_pipe_pkg::FWD_MEM: return mem_v;
			core_pipe_pkg::FWD_WB:  return wb_v;
			default:                return reg_v;
		endcase
	endfunction

	// rs2 also carries the SW store data
	assign op_a = fwd_mux(fwd_a, exe_a, mem_result, wb_data);
	assign op_b = fwd_mux(fwd_b, exe_b, mem_result, wb_data);

	always_comb begin
		case (exe_op)
			core_isa_pkg::OP_ADD:  alu = op_a + op_b;
			core_isa_pkg::OP_SUB:  alu = op_a - op_b;
			core_isa_pkg::OP_AND:  alu = op_a & op_b;
			core_isa_pkg::OP_ADDI,
			core_isa_pkg::OP_LW,
			core_isa_pkg::OP_SW:   alu = op_a + exe_imm;
			// return address
			core_isa_pkg::OP_JAL:  alu = core_isa_pkg::word_t'(exe_pc) + 1'b1;
			default:               alu = '0;
		endcase
	end

	// ----------------------------------------
	// branch and jump resolution
	// ----------------------------------------
	assign exe_taken = exe_valid && (exe_op == core_isa_pkg::OP_JAL
		|| (exe_op == core_isa_pkg::OP_BEQ && op_a == op_b));
	assign redirect_pc = exe_pc + core_isa_pkg::pc_t'(exe_imm);

	always_ff @(posedge clk) begin
		if (!rst_n || kill_exe_mem) begin
			mem_valid <= 1'b0;
			mem_we    <= 1'b0;
		end else if (enb_exe_mem) begin
			mem_valid <= exe_valid;
			mem_we    <= exe_we;
		end
	end

	always_ff @(posedge clk) begin
		if (enb_exe_mem) begin
			mem_op         <= exe_op;
			mem_rd         <= exe_rd;
			mem_result     <= alu;
			mem_store_data <= op_b;
		end
	end

endmodule

`default_nettype wire

// ==== design/core_memory.sv ====
// ----------------------------------------
// memory stage
// data memory, load/store path and the
// memory-to-write-back register
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module core_memory (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire core_isa_pkg::opcode_e  mem_op,
	input  wire core_isa_pkg::reg_t     mem_rd,
	input  wire                         mem_we,
	input  wire core_isa_pkg::word_t    mem_result,
	input  wire core_isa_pkg::word_t    mem_store_data,
	input  wire                         mem_valid,
	input  wire                         enb_mem_wb,
	input  wire                         kill_mem_wb,
	output logic                        wb_we,
	output core_isa_pkg::reg_t          wb_rd,
	output core_isa_pkg::word_t         wb_data
);

	core_isa_pkg::word_t  dmem [2**core_isa_pkg::DMEM_AW];
	core_isa_pkg::daddr_t addr;
	logic                 store;

	// word address, upper bits ignored so it wraps
	assign addr  = core_isa_pkg::daddr_t'(mem_result);
	// a store lands once, when the stage moves on
	assign store = mem_valid && mem_op == core_isa_pkg::OP_SW && enb_mem_wb;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**core_isa_pkg::DMEM_AW; i++)
				dmem[i] <= '0;
		end else if (store) begin
			dmem[addr] <= mem_store_data;
		end
	end

	// ----------------------------------------
	// write-back register
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n || kill_mem_wb)
			wb_we <= 1'b0;
		else if (enb_mem_wb)
			wb_we <= mem_we;
	end

	always_ff @(posedge clk) begin
		if (enb_mem_wb) begin
			wb_rd   <= mem_rd;
			wb_data <= (mem_op == core_isa_pkg::OP_LW) ? dmem[addr] : mem_result;
		end
	end

endmodule

`default_nettype wire

// ==== design/core_top.sv ====
// ----------------------------------------
// core_lite top level
// five pipeline stages around the hazard
// controller, load, hold and write-back ports
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module core_top (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       imem_we,
	input  wire core_isa_pkg::pc_t    imem_addr,
	input  wire core_isa_pkg::word_t  imem_data,
	input  wire                       hold,
	output logic                      wb_valid,
	output core_isa_pkg::reg_t        wb_rd,
	output core_isa_pkg::word_t       wb_data
);

	logic [core_pipe_pkg::NUM_STG-1:0] enb;
	logic [core_pipe_pkg::NUM_STG-1:0] kill;
	logic                     pc_stop;
	logic                     redirect;
	core_isa_pkg::pc_t        redirect_pc;
	core_pipe_pkg::fwd_sel_e  fwd_a;
	core_pipe_pkg::fwd_sel_e  fwd_b;
	// fetch to decode
	core_isa_pkg::word_t      dec_instr;
	core_isa_pkg::pc_t        dec_pc;
	logic                     dec_valid;
	core_isa_pkg::reg_t       dec_rs1;
	core_isa_pkg::reg_t       dec_rs2;
	core_pipe_pkg::hz_cmd_e   dec_cmd;
	// decode to execute
	core_isa_pkg::opcode_e    exe_op;
	core_isa_pkg::reg_t       exe_rs1;
	core_isa_pkg::reg_t       exe_rs2;
	core_isa_pkg::reg_t       exe_rd;
	logic                     exe_we;
	core_pipe_pkg::hz_cmd_e   exe_cmd;
	core_isa_pkg::word_t      exe_a;
	core_isa_pkg::word_t      exe_b;
	core_isa_pkg::word_t      exe_imm;
	core_isa_pkg::pc_t        exe_pc;
	logic                     exe_valid;
	logic                     exe_taken;
	// execute to memory
	core_isa_pkg::opcode_e    mem_op;
	core_isa_pkg::reg_t       mem_rd;
	logic                     mem_we;
	core_isa_pkg::word_t      mem_result;
	core_isa_pkg::word_t      mem_store_data;
	logic                     mem_valid;
	logic                     wb_we;

	// a held write-back stage retires once, after hold drops
	assign wb_valid = wb_we && !hold;

	core_fetch u_core_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.imem_we     (imem_we),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.enb_if_dec  (enb[core_pipe_pkg::STG_IF_DEC]),
		.kill_if_dec (kill[core_pipe_pkg::STG_IF_DEC]),
		.pc_stop     (pc_stop),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.dec_instr   (dec_instr),
		.dec_pc      (dec_pc),
		.dec_valid   (dec_valid)
	);

	core_decode u_core_decode (
		.clk          (clk),
		.rst_n        (rst_n),
		.dec_instr    (dec_instr),
		.dec_pc       (dec_pc),
		.dec_valid    (dec_valid),
		.enb_dec_exe  (enb[core_pipe_pkg::STG_DEC_EXE]),
		.kill_dec_exe (kill[core_pipe_pkg::STG_DEC_EXE]),
		.wb_we        (wb_we),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data),
		.dec_rs1      (dec_rs1),
		.dec_rs2      (dec_rs2),
		.dec_cmd      (dec_cmd),
		.exe_op       (exe_op),
		.exe_rs1      (exe_rs1),
		.exe_rs2      (exe_rs2),
		.exe_rd       (exe_rd),
		.exe_we       (exe_we),
		.exe_cmd      (exe_cmd),
		.exe_a        (exe_a),
		.exe_b        (exe_b),
		.exe_imm      (exe_imm),
		.exe_pc       (exe_pc),
		.exe_valid    (exe_valid)
	);

	core_execute u_core_execute (
		.clk            (clk),
		.rst_n          (rst_n),
		.exe_op         (exe_op),
		.exe_rd         (exe_rd),
		.exe_we         (exe_we),
		.exe_a          (exe_a),
		.exe_b          (exe_b),
		.exe_imm        (exe_imm),
		.exe_pc         (exe_pc),
		.exe_valid      (exe_valid),
		.fwd_a          (fwd_a),
		.fwd_b          (fwd_b),
		.wb_data        (wb_data),
		.enb_exe_mem    (enb[core_pipe_pkg::STG_EXE_MEM]),
		.kill_exe_mem   (kill[core_pipe_pkg::STG_EXE_MEM]),
		.exe_taken      (exe_taken),
		.redirect_pc    (redirect_pc),
		.mem_op         (mem_op),
		.mem_rd         (mem_rd),
		.mem_we         (mem_we),
		.mem_result     (mem_result),
		.mem_store_data (mem_store_data),
		.mem_valid      (mem_valid)
	);

	core_memory u_core_memory (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_op         (mem_op),
		.mem_rd         (mem_rd),
		.mem_we         (mem_we),
		.mem_result     (mem_result),
		.mem_store_data (mem_store_data),
		.mem_valid      (mem_valid),
		.enb_mem_wb     (enb[core_pipe_pkg::STG_MEM_WB]),
		.kill_mem_wb    (kill[core_pipe_pkg::STG_MEM_WB]),
		.wb_we          (wb_we),
		.wb_rd          (wb_rd),
		.wb_data        (wb_data)
	);

	core_hazard_ctrl u_core_hazard_ctrl (
		.rst_n     (rst_n),
		.hold      (hold),
		.dec_rs1   (dec_rs1),
		.dec_rs2   (dec_rs2),
		.dec_cmd   (dec_cmd),
		.exe_rs1   (exe_rs1),
		.exe_rs2   (exe_rs2),
		.exe_rd    (exe_rd),
		.exe_cmd   (exe_cmd),
		.exe_we    (exe_we),
		.exe_taken (exe_taken),
		.mem_rd    (mem_rd),
		.mem_we    (mem_we),
		.wb_rd     (wb_rd),
		.wb_we     (wb_we),
		.enb       (enb),
		.kill      (kill),
		.pc_stop   (pc_stop),
		.redirect  (redirect),
		.fwd_a     (fwd_a),
		.fwd_b     (fwd_b)
	);

endmodule

`default_nettype wire

// ==== tests/core_hazard_chk.sv ====
// ----------------------------------------
// hazard controller assertions
// kill on taken flow change, no forwarding
// of x0 from memory, hold freezes enables
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module core_hazard_chk (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           hold,
	input  wire                           exe_taken,
	input  wire [core_pipe_pkg::NUM_STG-1:0] enb,
	input  wire [core_pipe_pkg::NUM_STG-1:0] kill,
	input  wire core_pipe_pkg::fwd_sel_e  fwd_a,
	input  wire core_pipe_pkg::fwd_sel_e  fwd_b,
	input  wire core_isa_pkg::reg_t       exe_rs1,
	input  wire core_isa_pkg::reg_t       exe_rs2
);

	// number of failed assertions so far
	int n_fail = 0;

	// taken flow change flushes the two younger stages
	a_taken_kill: assert property (@(posedge clk) disable iff (!rst_n)
		exe_taken && !hold |-> kill[core_pipe_pkg::STG_IF_DEC]
			&& kill[core_pipe_pkg::STG_DEC_EXE])
		else begin
			$error("taken branch without flush");
			n_fail++;
		end

	a_fwd_a_x0: assert property (@(posedge clk) disable iff (!rst_n)
		exe_rs1 == '0 |-> fwd_a != core_pipe_pkg::FWD_MEM)
		else begin
			$error("x0 forwarded on operand a");
			n_fail++;
		end

	a_fwd_b_x0: assert property (@(posedge clk) disable iff (!rst_n)
		exe_rs2 == '0 |-> fwd_b != core_pipe_pkg::FWD_MEM)
		else begin
			$error("x0 forwarded on operand b");
			n_fail++;
		end

	a_hold_enb: assert property (@(posedge clk) disable iff (!rst_n)
		hold |-> enb == '0)
		else begin
			$error("stage enabled during hold");
			n_fail++;
		end

endmodule

// sampled on the core clock, beside the controller instance
bind core_top core_hazard_chk u_core_hazard_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.hold      (hold),
	.exe_taken (exe_taken),
	.enb       (enb),
	.kill      (kill),
	.fwd_a     (fwd_a),
	.fwd_b     (fwd_b),
	.exe_rs1   (exe_rs1),
	.exe_rs2   (exe_rs2)
);

`default_nettype wire

// ==== tests/core_tb.sv ====
// ----------------------------------------
// core_lite testbench
// random program, ISA reference model,
// write-back comparison, hold and timeout
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module core_tb;

	localparam int N_INSTR = 48;
	localparam int LAST    = N_INSTR - 1;

	logic clk;
	logic rst_n;
	logic imem_we;
	core_isa_pkg::pc_t   imem_addr;
	core_isa_pkg::word_t imem_data;
	logic hold;
	logic wb_valid;
	core_isa_pkg::reg_t  wb_rd;
	core_isa_pkg::word_t wb_data;

	logic [31:0] lfsr = 32'hc7e575c0;
	core_isa_pkg::opcode_e p_op [N_INSTR];
	core_isa_pkg::reg_t    p_rd [N_INSTR];
	core_isa_pkg::reg_t    p_rs1 [N_INSTR];
	core_isa_pkg::reg_t    p_rs2 [N_INSTR];
	logic [12:0]           p_imm [N_INSTR];
	// each entry is {rd, data}
	logic [36:0] exp_q [$];
	logic [36:0] exp_e;
	int cycles = 0;
	int hold_cnt = 0;
	int quiet = 0;
	int n_retired = 0;
	logic finished = 1'b0;

	core_top u_core_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.imem_we   (imem_we),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.hold      (hold),
		.wb_valid  (wb_valid),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act)
			fail_run($sformatf("** Error %s: expected 0x%0h, actual 0x%0h", name, exp, act));
	endtask

	// ----------------------------------------
	// program generator
	// ----------------------------------------
	task automatic build_program();
		logic [31:0] b;
		logic [31:0] off;
		for (int i = 0; i < LAST; i++) begin
			take_bits(3, b);
			p_op[i] = core_isa_pkg::opcode_e'(b[3:0]);
			take_bits(3, b);
			p_rd[i] = b[4:0];
			take_bits(3, b);
			p_rs1[i] = b[4:0];
			take_bits(3, b);
			p_rs2[i] = b[4:0];
			take_bits(8, b);
			p_imm[i] = {{5{b[7]}}, b[7:0]};
			if (p_op[i] inside {core_isa_pkg::OP_LW, core_isa_pkg::OP_SW})
				p_imm[i] = {{6{b[6]}}, b[6:0]};
			if (p_op[i] inside {core_isa_pkg::OP_BEQ, core_isa_pkg::OP_JAL}) begin
				take_bits(2, off);
				off = off + 1;
				if (i + off > LAST)
					off = LAST - i;
				p_imm[i] = off[12:0];
			end
			// reload what the previous store wrote
			take_bits(1, b);
			if (i > 0 && p_op[i-1] == core_isa_pkg::OP_SW && b[0]) begin
				p_op[i]  = core_isa_pkg::OP_LW;
				p_rs1[i] = p_rs1[i-1];
				p_imm[i] = p_imm[i-1];
			end
		end
		// self-loop ends the program
		p_op[LAST]  = core_isa_pkg::OP_JAL;
		p_rd[LAST]  = '0;
		p_rs1[LAST] = '0;
		p_rs2[LAST] = '0;
		p_imm[LAST] = '0;
	endtask

	// ISA model that fills the expected write-back list in program order
	function automatic void run_reference();
		logic [31:0] r [8];
		logic [31:0] dm [64];
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] res;
		logic wr;
		int pc;
		int steps;
		foreach (r[k]) r[k] = '0;
		foreach (dm[k]) dm[k] = '0;
		pc = 0;
		steps = 0;
		while (pc != LAST && steps < 200) begin
			a = r[p_rs1[pc][2:0]];
			b = r[p_rs2[pc][2:0]];
			imm = {{19{p_imm[pc][12]}}, p_imm[pc]};
			wr = 1'b1;
			res = '0;
			case (p_op[pc])
				core_isa_pkg::OP_ADD:  res = a + b;
				core_isa_pkg::OP_SUB:  res = a - b;
				core_isa_pkg::OP_AND:  res = a & b;
				core_isa_pkg::OP_ADDI: res = a + imm;
				core_isa_pkg::OP_LW:   res = dm[(a + imm) & 32'd63];
				core_isa_pkg::OP_SW: begin
					dm[(a + imm) & 32'd63] = b;
					wr = 1'b0;
				end
				core_isa_pkg::OP_JAL: res = pc + 1;
				default: wr = 1'b0;
			endcase
			if (wr && p_rd[pc] != '0) begin
				r[p_rd[pc][2:0]] = res;
				exp_q.push_back({p_rd[pc], res});
			end
			if (p_op[pc] == core_isa_pkg::OP_JAL)
				pc = pc + int'(imm);
			else if (p_op[pc] == core_isa_pkg::OP_BEQ && a == b)
				pc = pc + int'(imm);
			else
				pc = pc + 1;
			steps++;
		end
	endfunction

	// ----------------------------------------
	// comparison, quiet detection, timeout
	// ----------------------------------------
	always @(posedge clk) begin
		if (rst_n) begin
			cycles++;
			if (u_core_top.u_core_hazard_chk.n_fail != 0)
				fail_run("a hazard controller assertion failed");
			if (hold)
				hold_cnt++;
			if (hold && wb_valid)
				fail_run("wb_valid was high while hold was asserted");
			if (wb_valid) begin
				if (exp_q.size() == 0)
					fail_run("a write-back retired after the expected list was empty");
				exp_e = exp_q.pop_front();
				check_value($sformatf("wb_rd[%0d]", n_retired), 32'(exp_e[36:32]), 32'(wb_rd));
				check_value($sformatf("wb_data[%0d]", n_retired), exp_e[31:0], wb_data);
				n_retired++;
				quiet = 0;
			end else if (exp_q.size() == 0 && !hold) begin
				quiet++;
			end
			if (quiet >= 20)
				finished = 1'b1;
			if (cycles > N_INSTR * 4 + hold_cnt + 100)
				fail_run("timeout, the pipeline stopped retiring instructions");
		end
	end

	initial begin
		logic [31:0] b;
		rst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		hold = 1'b0;
		build_program();
		run_reference();
		// tail words past the program jump back to the self-loop
		for (int a = 0; a < 64; a++) begin
			@(negedge clk);
			imem_we = 1'b1;
			imem_addr = a[5:0];
			if (a < N_INSTR)
				imem_data = core_isa_pkg::encode(p_op[a], p_rd[a], p_rs1[a], p_rs2[a], p_imm[a]);
			else
				imem_data = core_isa_pkg::encode(core_isa_pkg::OP_JAL, '0, '0, '0,
					13'(LAST - a));
		end
		@(negedge clk);
		imem_we = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		// hold roughly one cycle in eight
		while (!finished) begin
			@(negedge clk);
			take_bits(3, b);
			hold = &b[2:0];
		end
		hold = 1'b0;
		$display("retired %0d instructions", n_retired);
		if (u_core_top.u_core_hazard_chk.n_fail != 0)
			fail_run("a hazard controller assertion failed");
		else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== core_lite.f ====
design/core_isa_pkg.sv
design/core_pipe_pkg.sv
design/core_hazard_ctrl.sv
design/core_fetch.sv
design/core_decode.sv
design/core_execute.sv
design/core_memory.sv
design/core_top.sv
tests/core_hazard_chk.sv
tests/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core_lite testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f core_lite.f \
	--top-module core_tb \
	-o Vcore_tb

./obj_dir/Vcore_tb | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	echo "run_sim: pass"
	exit 0
else
	echo "run_sim: fail"
	exit 1
fi
